//--- logic/lsu_byte_align.sv
//********************************************************************
// dc2 access alignment, purely combinational
// an access spans at most two words, lo holds the first byte
// enables are zero when no access is present
//********************************************************************
`timescale 1ns/1ns
`default_nettype none

module lsu_byte_align
   import lsu_fwd_pkg::*;
#(
   parameter int ADDR_WIDTH = 32
) (
   input  lsu_op_e                               op_dc2,
   input  lsu_size_e                             size_dc2,
   input  logic [ADDR_WIDTH-1:0]                 addr_dc2,
   input  logic [DATA_WIDTH-1:0]                 store_data_dc2,
   output logic [ADDR_WIDTH-1:BYTE_OFFSET_BITS]  word_addr_lo,   // word of the first byte
   output logic [ADDR_WIDTH-1:BYTE_OFFSET_BITS]  word_addr_hi,   // word of the last byte
   output logic [BYTES_PER_WORD-1:0]             byteen_lo,
   output logic [BYTES_PER_WORD-1:0]             byteen_hi,
   output logic [DATA_WIDTH-1:0]                 data_lo,
   output logic [DATA_WIDTH-1:0]                 data_hi
);

   localparam int WORD_ADDR_W = ADDR_WIDTH - BYTE_OFFSET_BITS;

   logic [BYTES_PER_WORD-1:0]   byteen_base;
   logic [2*BYTES_PER_WORD-1:0] byteen_ext;
   logic [2*DATA_WIDTH-1:0]     data_ext;
   logic [BYTE_OFFSET_BITS-1:0] byte_offset;
   logic                        crosses_word;

   assign byte_offset = addr_dc2[BYTE_OFFSET_BITS-1:0];

   // enable pattern before the offset is applied
   always_comb begin
      case (size_dc2)
         size_byte: byteen_base = 4'b0001;
         size_half: byteen_base = 4'b0011;
         size_word: byteen_base = 4'b1111;
         default:   byteen_base = 4'b0000;
      endcase
      if (op_dc2 == op_none) begin
         byteen_base = '0;
      end
   end

   // spread over two words, upper half is the next word
   assign byteen_ext = {{BYTES_PER_WORD{1'b0}}, byteen_base} << byte_offset;
   assign data_ext   = {{DATA_WIDTH{1'b0}}, store_data_dc2} << {byte_offset, 3'b000};

   assign byteen_lo = byteen_ext[BYTES_PER_WORD-1:0];
   assign byteen_hi = byteen_ext[2*BYTES_PER_WORD-1:BYTES_PER_WORD];
   assign data_lo   = data_ext[DATA_WIDTH-1:0];
   assign data_hi   = data_ext[2*DATA_WIDTH-1:DATA_WIDTH];

   assign crosses_word = |byteen_hi;
   assign word_addr_lo = addr_dc2[ADDR_WIDTH-1:BYTE_OFFSET_BITS];
   assign word_addr_hi = word_addr_lo + WORD_ADDR_W'(crosses_word);  // wraps at the top

endmodule

`default_nettype wire

//--- logic/lsu_fwd_match.sv
//********************************************************************
// compare of the dc2 access against one store stage
// the access kind is not checked here, the merge gates on op_load
// outputs are in the lanes of the load's lo and hi words
//********************************************************************
`timescale 1ns/1ns
`default_nettype none

module lsu_fwd_match
   import lsu_fwd_pkg::*;
#(
   parameter int ADDR_WIDTH = 32
) (
   // dc2 access
   input  logic [ADDR_WIDTH-1:BYTE_OFFSET_BITS]  word_addr_lo,
   input  logic [ADDR_WIDTH-1:BYTE_OFFSET_BITS]  word_addr_hi,
   input  logic [BYTES_PER_WORD-1:0]             byteen_lo,
   input  logic [BYTES_PER_WORD-1:0]             byteen_hi,

   // one older store
   input  logic                                  st_valid,
   input  logic [ADDR_WIDTH-1:BYTE_OFFSET_BITS]  st_addr_lo,
   input  logic [ADDR_WIDTH-1:BYTE_OFFSET_BITS]  st_addr_hi,
   input  logic [BYTES_PER_WORD-1:0]             st_byteen_lo,
   input  logic [BYTES_PER_WORD-1:0]             st_byteen_hi,
   input  logic [DATA_WIDTH-1:0]                 st_data_lo,
   input  logic [DATA_WIDTH-1:0]                 st_data_hi,

   output logic [BYTES_PER_WORD-1:0]             hit_lo,
   output logic [BYTES_PER_WORD-1:0]             hit_hi,
   output logic [DATA_WIDTH-1:0]                 fwd_lo,
   output logic [DATA_WIDTH-1:0]                 fwd_hi
);

   // naming is <load word>_<store word>
   logic                      addr_lo_lo, addr_lo_hi, addr_hi_lo, addr_hi_hi;
   logic [BYTES_PER_WORD-1:0] byte_lo_lo, byte_lo_hi, byte_hi_lo, byte_hi_hi;

   //******************************************************************
   // word address compares
   //******************************************************************
   assign addr_lo_lo = st_valid & (word_addr_lo == st_addr_lo);
   assign addr_lo_hi = st_valid & (word_addr_lo == st_addr_hi);
   assign addr_hi_lo = st_valid & (word_addr_hi == st_addr_lo);
   assign addr_hi_hi = st_valid & (word_addr_hi == st_addr_hi);

   // both sides must enable the byte
   assign byte_lo_lo = {BYTES_PER_WORD{addr_lo_lo}} & byteen_lo & st_byteen_lo;
   assign byte_lo_hi = {BYTES_PER_WORD{addr_lo_hi}} & byteen_lo & st_byteen_hi;
   assign byte_hi_lo = {BYTES_PER_WORD{addr_hi_lo}} & byteen_hi & st_byteen_lo;
   assign byte_hi_hi = {BYTES_PER_WORD{addr_hi_hi}} & byteen_hi & st_byteen_hi;

   assign hit_lo = byte_lo_lo | byte_lo_hi;
   assign hit_hi = byte_hi_lo | byte_hi_hi;

   //******************************************************************
   // data, a store byte lives in only one of its two words
   //******************************************************************
   for (genvar b = 0; b < BYTES_PER_WORD; b++) begin : g_byte
      assign fwd_lo[8*b +: 8] = ({8{byte_lo_lo[b]}} & st_data_lo[8*b +: 8]) |
                                ({8{byte_lo_hi[b]}} & st_data_hi[8*b +: 8]);
      assign fwd_hi[8*b +: 8] = ({8{byte_hi_lo[b]}} & st_data_lo[8*b +: 8]) |
                                ({8{byte_hi_hi[b]}} & st_data_hi[8*b +: 8]);
   end

endmodule

`default_nettype wire

//--- logic/lsu_fwd_merge.sv
//********************************************************************
// picks each load byte from the youngest hitting store (dc3 first)
// result is right aligned and zero filled, then registered into dc3
// forwarded data replaces bus data only on a full hit
// side effect loads can still report a partial hit
//********************************************************************
`timescale 1ns/1ns
`default_nettype none

module lsu_fwd_merge
   import lsu_fwd_pkg::*;
(
   input  logic                        clk,
   input  logic                        arst_n,
   input  lsu_op_e                     op_dc2,
   input  logic                        is_sideeffects_dc2,
   input  logic [BYTE_OFFSET_BITS-1:0] byte_offset_dc2,
   input  logic [BYTES_PER_WORD-1:0]   load_byteen_lo,
   input  logic [BYTES_PER_WORD-1:0]   load_byteen_hi,
   input  logic [BYTES_PER_WORD-1:0]   hit_lo [FWD_STAGES],   // index 0 is dc3
   input  logic [BYTES_PER_WORD-1:0]   hit_hi [FWD_STAGES],
   input  logic [DATA_WIDTH-1:0]       fwd_lo [FWD_STAGES],
   input  logic [DATA_WIDTH-1:0]       fwd_hi [FWD_STAGES],
   input  logic [DATA_WIDTH-1:0]       ld_bus_data_dc3,
   output logic                        ld_hit_dc3,
   output logic                        ld_full_hit_dc3,
   output logic [DATA_WIDTH-1:0]       bus_read_data_dc3
);

   logic [BYTES_PER_WORD-1:0] any_hit_lo, any_hit_hi;
   logic [DATA_WIDTH-1:0]     merged_lo, merged_hi;
   logic                      full_hit_lo, full_hit_hi;
   logic                      is_load_dc2;
   logic                      ld_hit_dc2, ld_full_hit_dc2;
   logic [DATA_WIDTH-1:0]     ld_fwddata_dc2, ld_fwddata_dc3;

   //******************************************************************
   // age priority, walk oldest to youngest so dc3 wins
   //******************************************************************
   always_comb begin
      any_hit_lo = '0;
      any_hit_hi = '0;
      merged_lo  = '0;
      merged_hi  = '0;
      for (int s = FWD_STAGES-1; s >= 0; s--) begin
         any_hit_lo |= hit_lo[s];
         any_hit_hi |= hit_hi[s];
         for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (hit_lo[s][b]) begin
               merged_lo[8*b +: 8] = fwd_lo[s][8*b +: 8];
            end
            if (hit_hi[s][b]) begin
               merged_hi[8*b +: 8] = fwd_hi[s][8*b +: 8];
            end
         end
      end
   end

   // every enabled byte must be covered by some store
   assign full_hit_lo = &(any_hit_lo | ~load_byteen_lo);
   assign full_hit_hi = &(any_hit_hi | ~load_byteen_hi);

   assign is_load_dc2     = (op_dc2 == op_load);
   assign ld_hit_dc2      = is_load_dc2 & ((|any_hit_lo) | (|any_hit_hi));
   assign ld_full_hit_dc2 = is_load_dc2 & ~is_sideeffects_dc2 & full_hit_lo & full_hit_hi;

   // bytes outside the load are zero, so this also zero extends
   assign ld_fwddata_dc2 = DATA_WIDTH'({merged_hi, merged_lo} >> {byte_offset_dc2, 3'b000});

   //******************************************************************
   // dc3 register
   //******************************************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ld_hit_dc3      <= 1'b0;
         ld_full_hit_dc3 <= 1'b0;
      end else begin
         ld_hit_dc3      <= ld_hit_dc2;
         ld_full_hit_dc3 <= ld_full_hit_dc2;
      end
   end

   always_ff @(posedge clk) begin
      ld_fwddata_dc3 <= ld_fwddata_dc2;
   end

   assign bus_read_data_dc3 = ld_full_hit_dc3 ? ld_fwddata_dc3 : ld_bus_data_dc3;

endmodule

`default_nettype wire

//--- logic/lsu_fwd_pkg.sv
//********************************************************************
// shared sizes and access encodings for the lsu store forwarding path
// one data word is 32 bits with byte granular enables
// FWD_STAGES is tied to the dc3..dc5 store pipe and is not a knob
//********************************************************************
`default_nettype none

package lsu_fwd_pkg;

   //******************************************************************
   // widths
   //******************************************************************
   localparam int DATA_WIDTH       = 32;
   localparam int BYTES_PER_WORD   = 4;   // width of one byte-enable word
   localparam int BYTE_OFFSET_BITS = 2;   // addr bits selecting a byte in a word
   localparam int FWD_STAGES       = 3;   // dc3, dc4, dc5

   //******************************************************************
   // access encodings
   //******************************************************************

   // kind of access sitting in dc2
   typedef enum logic [1:0] {
      op_none  = 2'b00,
      op_load  = 2'b01,
      op_store = 2'b10
   } lsu_op_e;

   // access size, 2'b11 is not used
   typedef enum logic [1:0] {
      size_byte = 2'b00,
      size_half = 2'b01,
      size_word = 2'b10
   } lsu_size_e;

endpackage

`default_nettype wire

//--- logic/lsu_store_fwd.sv
//********************************************************************
// store to load forwarding top, one access per cycle in dc2
// a load sees stores from the last three cycles, result one cycle later
// no back-pressure, flush drops every store in flight
// ADDR_WIDTH must be 8 or more
//********************************************************************
`timescale 1ns/1ns
`default_nettype none

module lsu_store_fwd
   import lsu_fwd_pkg::*;
#(
   parameter int ADDR_WIDTH = 32
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  lsu_op_e               op_dc2,
   input  lsu_size_e             size_dc2,
   input  logic [ADDR_WIDTH-1:0] addr_dc2,
   input  logic [DATA_WIDTH-1:0] store_data_dc2,
   input  logic                  is_sideeffects_dc2,
   input  logic                  flush,
   input  logic [DATA_WIDTH-1:0] ld_bus_data_dc3,    // read data from the bus side
   output logic                  ld_hit_dc3,
   output logic                  ld_full_hit_dc3,
   output logic [DATA_WIDTH-1:0] bus_read_data_dc3
);

   // aligned dc2 access
   logic [ADDR_WIDTH-1:BYTE_OFFSET_BITS] word_addr_lo, word_addr_hi;
   logic [BYTES_PER_WORD-1:0]            byteen_lo, byteen_hi;
   logic [DATA_WIDTH-1:0]                data_lo, data_hi;

   // store stages
   logic [FWD_STAGES-1:0]                stage_valid;
   logic [ADDR_WIDTH-1:BYTE_OFFSET_BITS] stage_addr_lo   [FWD_STAGES];
   logic [ADDR_WIDTH-1:BYTE_OFFSET_BITS] stage_addr_hi   [FWD_STAGES];
   logic [BYTES_PER_WORD-1:0]            stage_byteen_lo [FWD_STAGES];
   logic [BYTES_PER_WORD-1:0]            stage_byteen_hi [FWD_STAGES];
   logic [DATA_WIDTH-1:0]                stage_data_lo   [FWD_STAGES];
   logic [DATA_WIDTH-1:0]                stage_data_hi   [FWD_STAGES];

   // per stage match results
   logic [BYTES_PER_WORD-1:0]            hit_lo [FWD_STAGES];
   logic [BYTES_PER_WORD-1:0]            hit_hi [FWD_STAGES];
   logic [DATA_WIDTH-1:0]                fwd_lo [FWD_STAGES];
   logic [DATA_WIDTH-1:0]                fwd_hi [FWD_STAGES];

   lsu_byte_align #(.ADDR_WIDTH(ADDR_WIDTH)) u_byte_align (
      .op_dc2, .size_dc2, .addr_dc2, .store_data_dc2,
      .word_addr_lo, .word_addr_hi, .byteen_lo, .byteen_hi, .data_lo, .data_hi
   );

   lsu_store_pipe #(.ADDR_WIDTH(ADDR_WIDTH)) u_store_pipe (
      .clk, .arst_n, .flush, .op_dc2,
      .word_addr_lo, .word_addr_hi, .byteen_lo, .byteen_hi, .data_lo, .data_hi,
      .stage_valid, .stage_addr_lo, .stage_addr_hi,
      .stage_byteen_lo, .stage_byteen_hi, .stage_data_lo, .stage_data_hi
   );

   //******************************************************************
   // one matcher per store stage, g_match[0] is dc3
   //******************************************************************
   for (genvar s = 0; s < FWD_STAGES; s++) begin : g_match
      lsu_fwd_match #(.ADDR_WIDTH(ADDR_WIDTH)) u_match (
         .word_addr_lo (word_addr_lo),
         .word_addr_hi (word_addr_hi),
         .byteen_lo    (byteen_lo),
         .byteen_hi    (byteen_hi),
         .st_valid     (stage_valid[s]),
         .st_addr_lo   (stage_addr_lo[s]),
         .st_addr_hi   (stage_addr_hi[s]),
         .st_byteen_lo (stage_byteen_lo[s]),
         .st_byteen_hi (stage_byteen_hi[s]),
         .st_data_lo   (stage_data_lo[s]),
         .st_data_hi   (stage_data_hi[s]),
         .hit_lo       (hit_lo[s]),
         .hit_hi       (hit_hi[s]),
         .fwd_lo       (fwd_lo[s]),
         .fwd_hi       (fwd_hi[s])
      );
   end

   lsu_fwd_merge u_fwd_merge (
      .clk, .arst_n, .op_dc2, .is_sideeffects_dc2,
      .byte_offset_dc2 (addr_dc2[BYTE_OFFSET_BITS-1:0]),
      .load_byteen_lo  (byteen_lo),
      .load_byteen_hi  (byteen_hi),
      .hit_lo, .hit_hi, .fwd_lo, .fwd_hi,
      .ld_bus_data_dc3, .ld_hit_dc3, .ld_full_hit_dc3, .bus_read_data_dc3
   );

endmodule

`default_nettype wire

//--- logic/lsu_store_pipe.sv
//********************************************************************
// store pipe dc3 -> dc4 -> dc5, one cycle per stage
// only stores enter, loads and empty slots leave a bubble
// flush empties every stage and drops a store presented with it
//********************************************************************
`timescale 1ns/1ns
`default_nettype none

module lsu_store_pipe
   import lsu_fwd_pkg::*;
#(
   parameter int ADDR_WIDTH = 32
) (
   input  logic                                  clk,
   input  logic                                  arst_n,
   input  logic                                  flush,
   input  lsu_op_e                               op_dc2,
   input  logic [ADDR_WIDTH-1:BYTE_OFFSET_BITS]  word_addr_lo,
   input  logic [ADDR_WIDTH-1:BYTE_OFFSET_BITS]  word_addr_hi,
   input  logic [BYTES_PER_WORD-1:0]             byteen_lo,
   input  logic [BYTES_PER_WORD-1:0]             byteen_hi,
   input  logic [DATA_WIDTH-1:0]                 data_lo,
   input  logic [DATA_WIDTH-1:0]                 data_hi,

   // index 0 is dc3, FWD_STAGES-1 is dc5
   output logic [FWD_STAGES-1:0]                 stage_valid,
   output logic [ADDR_WIDTH-1:BYTE_OFFSET_BITS]  stage_addr_lo   [FWD_STAGES],
   output logic [ADDR_WIDTH-1:BYTE_OFFSET_BITS]  stage_addr_hi   [FWD_STAGES],
   output logic [BYTES_PER_WORD-1:0]             stage_byteen_lo [FWD_STAGES],
   output logic [BYTES_PER_WORD-1:0]             stage_byteen_hi [FWD_STAGES],
   output logic [DATA_WIDTH-1:0]                 stage_data_lo   [FWD_STAGES],
   output logic [DATA_WIDTH-1:0]                 stage_data_hi   [FWD_STAGES]
);

   logic store_dc2;

   assign store_dc2 = (op_dc2 == op_store);

   //******************************************************************
   // valid flags
   //******************************************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         stage_valid <= '0;
      end else if (flush) begin
         stage_valid <= '0;                  // kills dc2 store as well
      end else begin
         stage_valid[0] <= store_dc2;
         for (int s = 1; s < FWD_STAGES; s++) begin
            stage_valid[s] <= stage_valid[s-1];
         end
      end
   end

   //******************************************************************
   // payload, qualified by the valid flags above
   //******************************************************************
   always_ff @(posedge clk) begin
      if (store_dc2) begin
         stage_addr_lo[0]   <= word_addr_lo;
         stage_addr_hi[0]   <= word_addr_hi;
         stage_byteen_lo[0] <= byteen_lo;
         stage_byteen_hi[0] <= byteen_hi;
         stage_data_lo[0]   <= data_lo;
         stage_data_hi[0]   <= data_hi;
      end
      // older stages just follow
      for (int s = 1; s < FWD_STAGES; s++) begin
         stage_addr_lo[s]   <= stage_addr_lo[s-1];
         stage_addr_hi[s]   <= stage_addr_hi[s-1];
         stage_byteen_lo[s] <= stage_byteen_lo[s-1];
         stage_byteen_hi[s] <= stage_byteen_hi[s-1];
         stage_data_lo[s]   <= stage_data_lo[s-1];
         stage_data_hi[s]   <= stage_data_hi[s-1];
      end
   end

endmodule

`default_nettype wire

//--- lsu_store_fwd.f
logic/lsu_fwd_pkg.sv
logic/lsu_byte_align.sv
logic/lsu_store_pipe.sv
logic/lsu_fwd_match.sv
logic/lsu_fwd_merge.sv
logic/lsu_store_fwd.sv
tests/lsu_store_fwd_assertions.sv
tests/lsu_store_fwd_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the lsu_store_fwd testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module lsu_store_fwd_tb \
   -Mdir obj_dir \
   -f lsu_store_fwd.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/Vlsu_store_fwd_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
   exit 0
fi

echo "pass message not found in simulation output"
exit 1

//--- tests/lsu_store_fwd_assertions.sv
//********************************************************************
// protocol checks on the dc3 load result of lsu_store_fwd
// outputs are registered, so $past refers to the dc2 cycle
//********************************************************************
`timescale 1ns/1ns
`default_nettype none

module lsu_store_fwd_assertions
   import lsu_fwd_pkg::*;
(
   input logic    clk,
   input logic    arst_n,
   input lsu_op_e op_dc2,
   input logic    is_sideeffects_dc2,
   input logic    ld_hit_dc3,
   input logic    ld_full_hit_dc3
);

   // a full hit is always also a hit
   a_full_needs_hit : assert property (@(posedge clk) disable iff (!arst_n)
      ld_full_hit_dc3 |-> ld_hit_dc3)
      else $error("full hit without hit");

   a_hit_needs_load : assert property (@(posedge clk) disable iff (!arst_n)
      (ld_hit_dc3 || ld_full_hit_dc3) |-> ($past(op_dc2) == op_load))
      else $error("hit reported for a cycle without a load");

   a_full_no_side_effects : assert property (@(posedge clk) disable iff (!arst_n)
      ld_full_hit_dc3 |-> !$past(is_sideeffects_dc2))
      else $error("full hit on a load with side effects");

   a_hits_known : assert property (@(posedge clk) disable iff (!arst_n)
      !$isunknown({ld_hit_dc3, ld_full_hit_dc3}))
      else $error("hit outputs unknown");

endmodule

bind lsu_store_fwd lsu_store_fwd_assertions u_fwd_assertions (
   .clk                (clk),
   .arst_n             (arst_n),
   .op_dc2             (op_dc2),
   .is_sideeffects_dc2 (is_sideeffects_dc2),
   .ld_hit_dc3         (ld_hit_dc3),
   .ld_full_hit_dc3    (ld_full_hit_dc3)
);

`default_nettype wire

//--- tests/lsu_store_fwd_tb.sv
//********************************************************************
// testbench for lsu_store_fwd, one table row per clock cycle
// load results are checked at the negedge after the dc3 edge
// bus read data is random with a fixed seed
// the table ends idle so the last load reaches dc3
//********************************************************************
`timescale 1ns/1ns
`default_nettype none

module lsu_store_fwd_tb
   import lsu_fwd_pkg::*;
();

   localparam int ADDR_WIDTH    = 32;
   localparam int RESET_CYCLES  = 5;
   localparam int RESET_TIMEOUT = 20;

   // one cycle of dc2 stimulus plus the expected dc3 result of a load
   typedef struct packed {
      lsu_op_e                 op;
      lsu_size_e               size;
      logic [ADDR_WIDTH-1:0]   addr;
      logic [DATA_WIDTH-1:0]   data;
      logic                    side_eff;
      logic                    do_flush;
      logic                    exp_hit;
      logic                    exp_full;
      logic [DATA_WIDTH-1:0]   exp_fwd;
   } row_t;

   logic                  clk;
   logic                  arst_n;
   lsu_op_e               op_dc2;
   lsu_size_e             size_dc2;
   logic [ADDR_WIDTH-1:0] addr_dc2;
   logic [DATA_WIDTH-1:0] store_data_dc2;
   logic                  is_sideeffects_dc2;
   logic                  flush;
   logic [DATA_WIDTH-1:0] ld_bus_data_dc3;
   logic                  ld_hit_dc3;
   logic                  ld_full_hit_dc3;
   logic [DATA_WIDTH-1:0] bus_read_data_dc3;

   row_t rows[$];
   int   cur_row;

   lsu_store_fwd #(.ADDR_WIDTH(ADDR_WIDTH)) u_lsu_store_fwd (
      .clk, .arst_n, .op_dc2, .size_dc2, .addr_dc2, .store_data_dc2,
      .is_sideeffects_dc2, .flush, .ld_bus_data_dc3,
      .ld_hit_dc3, .ld_full_hit_dc3, .bus_read_data_dc3
   );

   //******************************************************************
   // table building
   //******************************************************************
   task automatic add_store(input lsu_size_e size, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] data, input logic do_flush);
      row_t r;
      r          = '0;
      r.op       = op_store;
      r.size     = size;
      r.addr     = addr;
      r.data     = data;
      r.do_flush = do_flush;
      rows.push_back(r);
   endtask

   task automatic add_load(input lsu_size_e size, input logic [ADDR_WIDTH-1:0] addr,
                           input logic side_eff, input logic exp_hit, input logic exp_full,
                           input logic [DATA_WIDTH-1:0] exp_fwd);
      row_t r;
      r          = '0;
      r.op       = op_load;
      r.size     = size;
      r.addr     = addr;
      r.side_eff = side_eff;
      r.exp_hit  = exp_hit;
      r.exp_full = exp_full;
      r.exp_fwd  = exp_fwd;    // right aligned, zero extended
      rows.push_back(r);
   endtask

   task automatic add_idle(input logic do_flush);
      row_t r;
      r          = '0;         // op_none
      r.do_flush = do_flush;
      rows.push_back(r);
   endtask

   task automatic build_table();
      // word store then word load
      add_store(size_word, 32'h100, 32'hdead_beef, 1'b0);
      add_load (size_word, 32'h100, 1'b0, 1'b1, 1'b1, 32'hdead_beef);
      add_idle(1'b0);
      add_idle(1'b0);
      add_idle(1'b0);
      // two byte stores into one word
      add_store(size_byte, 32'h200, 32'h0000_00aa, 1'b0);
      add_store(size_byte, 32'h202, 32'h0000_00bb, 1'b0);
      add_load (size_word, 32'h200, 1'b0, 1'b1, 1'b0, 32'h0);        // partial
      add_load (size_byte, 32'h200, 1'b0, 1'b1, 1'b1, 32'h0000_00aa);
      add_load (size_byte, 32'h202, 1'b0, 1'b1, 1'b1, 32'h0000_00bb);
      add_idle(1'b0);
      add_idle(1'b0);
      add_idle(1'b0);
      // younger store wins, then a store ages out after dc5
      add_store(size_byte, 32'h300, 32'h0000_0011, 1'b0);
      add_store(size_byte, 32'h300, 32'h0000_0022, 1'b0);
      add_load (size_byte, 32'h300, 1'b0, 1'b1, 1'b1, 32'h0000_0022);
      add_store(size_byte, 32'h310, 32'h0000_0033, 1'b0);
      add_idle(1'b0);
      add_idle(1'b0);
      add_load (size_byte, 32'h310, 1'b0, 1'b1, 1'b1, 32'h0000_0033);  // store in dc5
      add_load (size_byte, 32'h310, 1'b0, 1'b0, 1'b0, 32'h0);          // store gone
      add_idle(1'b0);
      // half store across a word boundary
      add_store(size_half, 32'h403, 32'h0000_cdab, 1'b0);
      add_load (size_half, 32'h403, 1'b0, 1'b1, 1'b1, 32'h0000_cdab);
      add_load (size_byte, 32'h404, 1'b0, 1'b1, 1'b1, 32'h0000_00cd);  // upper word only
      add_idle(1'b0);
      add_idle(1'b0);
      add_idle(1'b0);
      // side effects block the full hit
      add_store(size_word, 32'h500, 32'h1234_5678, 1'b0);
      add_load (size_word, 32'h500, 1'b1, 1'b1, 1'b0, 32'h0);
      add_load (size_word, 32'h500, 1'b0, 1'b1, 1'b1, 32'h1234_5678);
      add_idle(1'b0);
      add_idle(1'b0);
      add_idle(1'b0);
      // flush kills stores in flight and the store presented with it
      add_store(size_word, 32'h600, 32'hcafe_f00d, 1'b0);
      add_idle(1'b1);
      add_load (size_word, 32'h600, 1'b0, 1'b0, 1'b0, 32'h0);
      add_store(size_word, 32'h610, 32'h0bad_beef, 1'b1);
      add_load (size_word, 32'h610, 1'b0, 1'b0, 1'b0, 32'h0);
      add_store(size_word, 32'h620, 32'h5566_7788, 1'b0);
      add_load (size_word, 32'h620, 1'b0, 1'b1, 1'b1, 32'h5566_7788);
      add_idle(1'b0);      // lets the last load reach dc3
   endtask

   //******************************************************************
   // drive and check
   //******************************************************************
   task automatic apply_row(input row_t r);
      op_dc2             <= r.op;
      size_dc2           <= r.size;
      addr_dc2           <= r.addr;
      store_data_dc2     <= r.data;
      is_sideeffects_dc2 <= r.side_eff;
      flush              <= r.do_flush;
   endtask

   task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] actual,
                              input logic [DATA_WIDTH-1:0] expected);
      if (actual !== expected) begin
         $display("Fail row %0d %s: got 0x%h, expected 0x%h", cur_row, name, actual, expected);
         $display("sim failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic check_load(input row_t r, input logic [DATA_WIDTH-1:0] bus_val);
      logic [DATA_WIDTH-1:0] exp_data;
      exp_data = r.exp_full ? r.exp_fwd : bus_val;   // bus data unless fully forwarded
      check_value("ld_hit_dc3", {{(DATA_WIDTH-1){1'b0}}, ld_hit_dc3},
                  {{(DATA_WIDTH-1){1'b0}}, r.exp_hit});
      check_value("ld_full_hit_dc3", {{(DATA_WIDTH-1){1'b0}}, ld_full_hit_dc3},
                  {{(DATA_WIDTH-1){1'b0}}, r.exp_full});
      check_value("bus_read_data_dc3", bus_read_data_dc3, exp_data);
   endtask

   task automatic wait_reset_done();
      int cycles;
      cycles = 0;
      while (arst_n !== 1'b1) begin
         @(posedge clk);
         cycles++;
         if (cycles > RESET_TIMEOUT) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("sim failed");
            $fatal(1, "reset timeout");
         end
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      arst_n <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
   end

   initial begin
      logic [DATA_WIDTH-1:0] bus_val;
      void'($urandom(98));
      op_dc2             <= op_none;
      size_dc2           <= size_byte;
      addr_dc2           <= '0;
      store_data_dc2     <= '0;
      is_sideeffects_dc2 <= 1'b0;
      flush              <= 1'b0;
      ld_bus_data_dc3    <= '0;
      cur_row            = -1;
      build_table();
      wait_reset_done();

      for (int i = 0; i < rows.size(); i++) begin
         @(posedge clk);
         bus_val = $urandom;
         ld_bus_data_dc3 <= bus_val;    // bus data for the load one row back
         apply_row(rows[i]);
         @(negedge clk);
         if (i > 0 && rows[i-1].op == op_load) begin
            cur_row = i - 1;
            check_load(rows[i-1], bus_val);
         end
      end
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire
